//--- dv/mips_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mips_tb;
   import mips_isa_pkg::*;

   localparam word_t text_start  = 32'h0040_0000;
   localparam int    n_prog      = 8;
   localparam int    prog_len    = 200;
   localparam int    cycle_limit = n_prog * (prog_len + 10 + 20);

   logic       clk;
   logic       por_b;
   logic       prog_rst_b;   // per-program reset
   logic       rst_b;
   logic       inst_excpt;
   logic       halted;
   logic [3:0] mem_write_en;
   word_addr_t inst_addr;
   word_addr_t inst_idx;
   word_addr_t mem_addr;
   word_t      inst;
   word_t      mem_data_in;
   word_t      mem_data_out;

   word_t      imem [256];   // program at text_start
   word_t      dmem [16];    // data window of bytes 0..63
   word_t      m_reg [32];   // model state
   word_t      m_mem [16];
   word_t      m_pc;
   logic       m_halted;
   logic [5:0] alu_fn [13];
   logic [5:0] imm_op [6];
   logic [5:0] ld_op [5];
   int         cycles = 0;

   mips_tb_clock clock_i (.clk(clk), .rst_b(por_b));

   assign rst_b = por_b & prog_rst_b;

   mips_core #(.text_start(text_start)) dut_i (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .inst_excpt(inst_excpt), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
      .mem_data_out(mem_data_out), .mem_write_en(mem_write_en), .halted(halted));

   // combinational memories
   assign inst_idx     = inst_addr - text_start[31:2];
   assign inst         = (inst_idx < 30'd256) ? imem[inst_idx[7:0]] : '0;
   assign mem_data_out = dmem[mem_addr[3:0]];

   always @(posedge clk) begin
      if (rst_b && (mem_write_en == 4'hf)) begin   // memory outputs ignored in reset
         dmem[mem_addr[3:0]] <= mem_data_in;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run took more than %0d cycles", cycle_limit);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_addr(input string name, input word_addr_t got, input word_addr_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "address mismatch");
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, logic [4:0] sh,
                                   logic [5:0] fn);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t enc_j(logic [5:0] op, int t);
      return {op, 26'((text_start >> 2) + t)};   // word index t in the program
   endfunction

   function automatic reg_idx_t pick_src();
      return 5'($urandom % 16);
   endfunction

   task automatic gen_program(input int mode);
      int       i;
      int       c;
      int       k;
      int       n;
      int       t;
      reg_idx_t rd;
      for (int j = 0; j < 256; j++) begin
         imem[j] = '0;   // sll $0 filler
      end
      i = 0;
      while (i < prog_len - 2) begin
         case (mode)
            0:       c = $urandom % 3;         // alu, imm, store
            1:       c = 1 + $urandom % 3;     // imm, store, load
            default: c = $urandom % 8;
         endcase
         rd = 5'(1 + $urandom % 15);
         n  = 1;
         t  = i + 1 + $urandom % (prog_len - 2 - i);   // forward up to the exit code
         case (c)
            0: imem[i] = enc_r(pick_src(), pick_src(), rd, 5'($urandom), alu_fn[$urandom % 13]);
            1: imem[i] = enc_i(imm_op[$urandom % 6], pick_src(), rd, 16'($urandom));
            2: imem[i] = enc_i(OP_SW, 5'd0, pick_src(), 16'(4 * ($urandom % 16)));
            3: begin
               k = $urandom % 5;
               t = 4 * ($urandom % 16);
               if (k == 1 || k == 2) t = t + $urandom % 4;           // byte lane
               else if (k >= 3) t = t + 2 * ($urandom % 2);         // half lane
               imem[i] = enc_i(ld_op[k], 5'd0, rd, 16'(t));
            end
            4: imem[i] = enc_i(($urandom % 2) ? OP_BNE : OP_BEQ, pick_src(), pick_src(),
                               16'(t - i - 1));
            5: if (($urandom % 2) || (i >= prog_len - 4)) begin
               imem[i] = enc_j(OP_J, t);
            end else begin
               imem[i]     = enc_j(OP_JAL, i + 2);   // skips one word
               imem[i + 1] = enc_i(OP_SW, 5'd0, 5'd0, 16'd0);   // a store here means a delay slot
               // link value goes out to memory
               imem[i + 2] = enc_i(OP_SW, 5'd0, reg_ra, 16'(4 * ($urandom % 16)));
               n = 3;
            end
            6: if (i < prog_len - 5) begin
               t = i + 3 + $urandom % (prog_len - 4 - i);
               imem[i]     = enc_i(OP_LUI, 5'd0, 5'd20, text_start[31:16]);
               imem[i + 1] = enc_i(OP_ORI, 5'd20, 5'd20, 16'(t * 4));
               imem[i + 2] = enc_r(5'd20, 5'd0, 5'd0, 5'd0, F_JR);
               n = 3;
            end
            default: if (i < prog_len - 3) begin
               imem[i]     = enc_i(OP_ADDIU, 5'd0, reg_v0, 16'($urandom % 10));   // not exit
               imem[i + 1] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, F_SYSCALL);
               n = 2;
            end
         endcase
         i = i + n;
      end
      imem[prog_len - 2] = enc_i(OP_ADDIU, 5'd0, reg_v0, 16'(syscall_exit));
      imem[prog_len - 1] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, F_SYSCALL);
   endtask

   // one instruction of the ISA model against this cycle's DUT outputs
   task automatic step_and_check(input logic excpt);
      word_t      w;
      word_t      a;
      word_t      b;
      word_t      sx;
      word_t      zx;
      word_t      addr;
      word_t      ld;
      word_t      res;
      word_t      nxt;
      logic [7:0] bv;
      logic [15:0] hv;
      logic [4:0] sh;
      reg_idx_t   widx;
      logic       we;
      logic       st;
      logic       halt;
      check_addr("inst_addr", inst_addr, m_pc[31:2]);
      check_flag("halted", halted, m_halted);
      if (m_halted) begin
         check_flag("mem_write_en", mem_write_en == 4'hf, 1'b0);   // frozen so no stores
         return;
      end
      w    = imem[8'((m_pc - text_start) >> 2)];
      a    = m_reg[w[25:21]];
      b    = m_reg[w[20:16]];
      sh   = w[10:6];
      sx   = {{16{w[15]}}, w[15:0]};
      zx   = {16'h0000, w[15:0]};
      addr = a + sx;
      ld   = m_mem[addr[5:2]];
      bv   = 8'(ld >> (8 * addr[1:0]));
      hv   = 16'(ld >> (16 * addr[1]));
      nxt  = m_pc + 4;
      widx = w[20:16];
      we   = 1'b1;
      st   = 1'b0;
      res  = '0;
      halt = excpt;
      case (w[31:26])
         6'h00: begin
            widx = w[15:11];
            case (w[5:0])
               6'h00: res = b << sh;
               6'h02: res = b >> sh;
               6'h03: res = $signed(b) >>> sh;
               6'h04: res = b << a[4:0];
               6'h06: res = b >> a[4:0];
               6'h07: res = $signed(b) >>> a[4:0];
               6'h08: begin
                  we  = 1'b0;
                  nxt = a;   // jr without delay slot
               end
               6'h0c: begin
                  we   = 1'b0;
                  halt = halt | (m_reg[2] == 32'd10);
               end
               6'h21: res = a + b;
               6'h23: res = a - b;
               6'h24: res = a & b;
               6'h25: res = a | b;
               6'h26: res = a ^ b;
               6'h27: res = ~(a | b);
               6'h2a: res = {31'd0, $signed(a) < $signed(b)};
               default: halt = 1'b1;
            endcase
         end
         6'h02: begin
            we  = 1'b0;
            nxt = {nxt[31:28], w[25:0], 2'b00};
         end
         6'h03: begin
            widx = 5'd31;
            res  = m_pc + 4;   // link
            nxt  = {nxt[31:28], w[25:0], 2'b00};
         end
         6'h04, 6'h05: begin
            we = 1'b0;
            if ((a == b) != w[26]) nxt = m_pc + 4 + (sx << 2);
         end
         6'h09: res = a + sx;
         6'h0a: res = {31'd0, $signed(a) < $signed(sx)};
         6'h0c: res = a & zx;
         6'h0d: res = a | zx;
         6'h0e: res = a ^ zx;
         6'h0f: res = {w[15:0], 16'h0000};
         6'h23: res = ld;
         6'h20: res = {{24{bv[7]}}, bv};
         6'h24: res = {24'd0, bv};
         6'h21: res = {{16{hv[15]}}, hv};
         6'h25: res = {16'd0, hv};
         6'h2b: begin
            we = 1'b0;
            st = 1'b1;
         end
         default: halt = 1'b1;   // unknown opcode
      endcase
      if (halt) st = 1'b0;
      check_flag("mem_write_en", mem_write_en == 4'hf, st);
      if (st) begin
         check_addr("mem_addr", mem_addr, addr[31:2]);
         check_word("mem_data_in", mem_data_in, b);
      end
      if (halt) begin
         m_halted = 1'b1;
      end else begin
         if (we && widx != 5'd0) m_reg[widx] = res;
         if (st) m_mem[addr[5:2]] = b;
         m_pc = nxt;
      end
   endtask

   initial begin
      int p;
      int cyc;
      int hold;
      int excpt_cyc;
      void'($urandom(90120));
      inst_excpt = 1'b0;
      prog_rst_b = 1'b0;
      alu_fn = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV, F_ADDU, F_SUBU,
                 F_AND, F_OR, F_XOR, F_NOR, F_SLT};
      imm_op = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      ld_op  = '{OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU};
      @(posedge por_b);
      for (p = 0; p < n_prog; p++) begin
         excpt_cyc = -1;
         gen_program((p % 4 == 3) ? 1 : p % 4);   // straight-line code reaches the halt point
         if (p % 4 == 3) begin
            if (p % 8 == 3) imem[20 + $urandom % 160] = {6'h3f, 26'($urandom)};   // bad op
            else excpt_cyc = 10 + $urandom % 150;
         end
         for (int k = 0; k < 16; k++) begin
            dmem[k]  = $urandom;
            m_mem[k] = dmem[k];
         end
         for (int r = 0; r < 32; r++) begin
            m_reg[r] = '0;
         end
         @(negedge clk);
         prog_rst_b = 1'b0;
         repeat (10) @(negedge clk);
         prog_rst_b = 1'b1;
         m_pc     = text_start;
         m_halted = 1'b0;
         hold     = 0;
         cyc      = 0;
         while (hold < 3) begin
            inst_excpt = (cyc == excpt_cyc);   // one-cycle pulse
            #1;
            step_and_check(inst_excpt);
            if (m_halted) hold++;
            cyc++;
            @(negedge clk);
         end
         inst_excpt = 1'b0;
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/mips_tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module mips_tb_clock (
   output logic clk,
   output logic rst_b
);
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      rst_b = 1'b0;
      repeat (10) @(negedge clk);   // power-on reset
      rst_b = 1'b1;
   end

endmodule

`default_nettype wire

//--- mips_lite.f
src/mips_isa_pkg.sv
src/mips_core_pkg.sv
src/mips_fetch.sv
src/mips_decode.sv
src/mips_regfile.sv
src/mips_execute.sv
src/mips_writeback.sv
src/mips_core.sv
dv/mips_tb_clock.sv
dv/mips_tb.sv

//--- run.sh
#!/bin/sh
# build and run the mips_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module mips_tb -f mips_lite.f -o mips_sim || exit 1
./obj_dir/mips_sim > sim.log 2>&1
cat sim.log
grep -q "Verification passed" sim.log || exit 1
grep -q "Verification failed" sim.log && exit 1 || exit 0

//--- src/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core #(
   parameter mips_isa_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic                      clk,
   input  logic                      rst_b,
   output mips_isa_pkg::word_addr_t  inst_addr,
   input  mips_isa_pkg::word_t       inst,
   input  logic                      inst_excpt,
   output mips_isa_pkg::word_addr_t  mem_addr,
   output mips_isa_pkg::word_t       mem_data_in,
   input  mips_isa_pkg::word_t       mem_data_out,
   output logic [3:0]                mem_write_en,
   output logic                      halted
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   word_t     pc;
   dec_t      dec;
   ex_t       ex;
   redirect_t redirect;
   reg_idx_t  rs_idx;
   reg_idx_t  rt_idx;
   reg_idx_t  wr_idx;
   word_t     rs_data;
   word_t     rt_data;
   word_t     wr_data;
   logic      wr_en;
   logic      halt_req;   // unknown op, syscall exit or inst_excpt

   mips_fetch #(.text_start(text_start)) fetch_i (
      .clk(clk), .rst_b(rst_b), .redirect(redirect), .halt_req(halt_req),
      .pc(pc), .inst_addr(inst_addr), .halted(halted));

   mips_decode decode_i (
      .inst(inst), .inst_excpt(inst_excpt), .rs_data(rs_data), .rt_data(rt_data),
      .rs_idx(rs_idx), .rt_idx(rt_idx), .dec(dec), .halt_req(halt_req));

   mips_regfile regfile_i (
      .clk(clk), .rst_b(rst_b), .rs_idx(rs_idx), .rt_idx(rt_idx), .wr_idx(wr_idx),
      .wr_en(wr_en), .wr_data(wr_data), .rs_data(rs_data), .rt_data(rt_data));

   mips_execute execute_i (
      .dec(dec), .pc(pc), .halted(halted), .ex(ex), .redirect(redirect),
      .mem_addr(mem_addr), .mem_data_in(mem_data_in), .mem_write_en(mem_write_en));

   mips_writeback writeback_i (
      .ex(ex), .mem_data_out(mem_data_out), .pc(pc), .halted(halted),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data));

endmodule

`default_nettype wire

//--- src/mips_core_pkg.sv
`default_nettype none

package mips_core_pkg;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,    // signed
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_SLLV,
      ALU_SRLV,
      ALU_SRAV
   } alu_op_e;

   typedef enum logic [2:0] {
      LD_NONE,
      LD_LW,
      LD_LB,
      LD_LBU,
      LD_LH,
      LD_LHU
   } load_kind_e;

   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BRANCH,
      PC_JUMP,
      PC_JR
   } pc_sel_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic       use_imm;        // operand b from immediate
      logic       shift_by_reg;   // shift amount from rs
      load_kind_e load_kind;
      logic       store;
      logic       reg_we;
      logic       link;           // write pc+4
      pc_sel_e    pc_sel;
      logic       branch_ne;
      logic       halt;
   } ctrl_t;

   // decode -> execute
   typedef struct packed {
      ctrl_t                  ctrl;
      mips_isa_pkg::word_t    rs_data;
      mips_isa_pkg::word_t    rt_data;
      mips_isa_pkg::word_t    imm;      // already extended
      logic [4:0]             shamt;
      mips_isa_pkg::reg_idx_t dst;
      logic [25:0]            target;
   } dec_t;

   // execute -> writeback
   typedef struct packed {
      mips_isa_pkg::word_t    result;
      mips_isa_pkg::reg_idx_t dst;
      load_kind_e             load_kind;
      logic                   reg_we;
      logic                   link;
   } ex_t;

   // execute -> fetch
   typedef struct packed {
      logic                take;
      mips_isa_pkg::word_t target;
   } redirect_t;

endpackage

`default_nettype wire

//--- src/mips_decode.sv
`timescale 1ns/10ps
`default_nettype none

module mips_decode (
   input  mips_isa_pkg::instr_t    inst,
   input  logic                    inst_excpt,
   input  mips_isa_pkg::word_t     rs_data,
   input  mips_isa_pkg::word_t     rt_data,
   output mips_isa_pkg::reg_idx_t  rs_idx,
   output mips_isa_pkg::reg_idx_t  rt_idx,
   output mips_core_pkg::dec_t     dec,
   output logic                    halt_req
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   ctrl_t      ctrl;        // raw control from the encoding
   ctrl_t      ctrl_out;    // after halt gating
   reg_idx_t   dst;
   word_t      imm_ext;
   logic [15:0] imm16;
   logic       zero_ext;
   logic       upper_ext;
   logic       unknown;
   logic       is_syscall;
   logic       is_lui;

   assign imm16      = inst[15:0];
   assign is_syscall = (inst.op == OP_SPECIAL) && (inst.funct == F_SYSCALL);
   assign is_lui     = (inst.op == OP_LUI);

   // syscall reads v0 through port a, LUI ORs into $zero
   assign rs_idx = is_syscall ? reg_v0 : (is_lui ? 5'd0 : inst.rs);
   assign rt_idx = inst.rt;

   always_comb begin
      ctrl = '{alu_op: ALU_ADD, use_imm: 1'b0, shift_by_reg: 1'b0, load_kind: LD_NONE,
               store: 1'b0, reg_we: 1'b0, link: 1'b0, pc_sel: PC_SEQ,
               branch_ne: 1'b0, halt: 1'b0};
      dst       = inst.rt;   // I-format default
      zero_ext  = 1'b0;
      upper_ext = 1'b0;
      unknown   = 1'b0;
      case (inst.op)
         OP_SPECIAL: begin
            dst         = inst.rd;
            ctrl.reg_we = 1'b1;
            case (inst.funct)
               F_SLL:  ctrl.alu_op = ALU_SLL;
               F_SRL:  ctrl.alu_op = ALU_SRL;
               F_SRA:  ctrl.alu_op = ALU_SRA;
               F_SLLV: begin
                  ctrl.alu_op       = ALU_SLLV;
                  ctrl.shift_by_reg = 1'b1;
               end
               F_SRLV: begin
                  ctrl.alu_op       = ALU_SRLV;
                  ctrl.shift_by_reg = 1'b1;
               end
               F_SRAV: begin
                  ctrl.alu_op       = ALU_SRAV;
                  ctrl.shift_by_reg = 1'b1;
               end
               F_JR: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = PC_JR;
               end
               F_SYSCALL: ctrl.reg_we = 1'b0;   // halt decided below
               F_ADDU: ctrl.alu_op = ALU_ADD;
               F_SUBU: ctrl.alu_op = ALU_SUB;
               F_AND:  ctrl.alu_op = ALU_AND;
               F_OR:   ctrl.alu_op = ALU_OR;
               F_XOR:  ctrl.alu_op = ALU_XOR;
               F_NOR:  ctrl.alu_op = ALU_NOR;
               F_SLT:  ctrl.alu_op = ALU_SLT;
               default: begin
                  ctrl.reg_we = 1'b0;
                  unknown     = 1'b1;
               end
            endcase
         end
         OP_J:   ctrl.pc_sel = PC_JUMP;
         OP_JAL: begin
            ctrl.pc_sel = PC_JUMP;
            ctrl.reg_we = 1'b1;
            ctrl.link   = 1'b1;
            dst         = reg_ra;
         end
         OP_BEQ: ctrl.pc_sel = PC_BRANCH;
         OP_BNE: begin
            ctrl.pc_sel    = PC_BRANCH;
            ctrl.branch_ne = 1'b1;
         end
         OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            case (inst.op)
               OP_SLTI: ctrl.alu_op = ALU_SLT;
               OP_ANDI: ctrl.alu_op = ALU_AND;
               OP_ORI:  ctrl.alu_op = ALU_OR;
               OP_XORI: ctrl.alu_op = ALU_XOR;
               OP_LUI:  ctrl.alu_op = ALU_OR;   // $zero | imm<<16
               default: ctrl.alu_op = ALU_ADD;
            endcase
            zero_ext  = (inst.op == OP_ANDI) || (inst.op == OP_ORI) || (inst.op == OP_XORI);
            upper_ext = is_lui;
         end
         OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            case (inst.op)
               OP_LB:   ctrl.load_kind = LD_LB;
               OP_LBU:  ctrl.load_kind = LD_LBU;
               OP_LH:   ctrl.load_kind = LD_LH;
               OP_LHU:  ctrl.load_kind = LD_LHU;
               default: ctrl.load_kind = LD_LW;
            endcase
         end
         OP_SW: begin
            ctrl.use_imm = 1'b1;   // rs + offset
            ctrl.store   = 1'b1;
         end
         default: unknown = 1'b1;
      endcase
   end

   assign imm_ext = upper_ext ? {imm16, 16'h0000} :
                    zero_ext  ? {16'h0000, imm16} :
                                {{16{imm16[15]}}, imm16};

   assign halt_req = unknown | inst_excpt | (is_syscall && (rs_data == syscall_exit));

   // a halting instruction leaves no trace
   always_comb begin
      ctrl_out      = ctrl;
      ctrl_out.halt = halt_req;
      if (halt_req) begin
         ctrl_out.reg_we = 1'b0;
         ctrl_out.store  = 1'b0;
         ctrl_out.pc_sel = PC_SEQ;
      end
   end

   assign dec = '{ctrl: ctrl_out, rs_data: rs_data, rt_data: rt_data, imm: imm_ext,
                  shamt: inst.shamt, dst: dst, target: inst[25:0]};

endmodule

`default_nettype wire

//--- src/mips_execute.sv
`timescale 1ns/10ps
`default_nettype none

module mips_execute (
   input  mips_core_pkg::dec_t       dec,
   input  mips_isa_pkg::word_t       pc,
   input  logic                      halted,
   output mips_core_pkg::ex_t        ex,
   output mips_core_pkg::redirect_t  redirect,
   output mips_isa_pkg::word_addr_t  mem_addr,
   output mips_isa_pkg::word_t       mem_data_in,
   output logic [3:0]                mem_write_en
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   word_t      op_a;
   word_t      op_b;
   word_t      alu_y;
   word_t      pc_plus4;
   word_t      br_target;
   word_t      j_target;
   logic [4:0] sh;

   assign op_a = dec.rs_data;
   assign op_b = dec.ctrl.use_imm ? dec.imm : dec.rt_data;
   assign sh   = dec.ctrl.shift_by_reg ? dec.rs_data[4:0] : dec.shamt;   // low 5 bits of rs

   always_comb begin
      case (dec.ctrl.alu_op)
         ALU_ADD:            alu_y = op_a + op_b;
         ALU_SUB:            alu_y = op_a - op_b;
         ALU_AND:            alu_y = op_a & op_b;
         ALU_OR:             alu_y = op_a | op_b;
         ALU_XOR:            alu_y = op_a ^ op_b;
         ALU_NOR:            alu_y = ~(op_a | op_b);
         ALU_SLT:            alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
         ALU_SLL, ALU_SLLV:  alu_y = op_b << sh;   // rt is the shifted value
         ALU_SRL, ALU_SRLV:  alu_y = op_b >> sh;
         ALU_SRA, ALU_SRAV:  alu_y = word_t'($signed(op_b) >>> sh);
         default:            alu_y = '0;
      endcase
   end

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {dec.imm[29:0], 2'b00};
   assign j_target  = {pc[31:28], dec.target, 2'b00};

   always_comb begin
      redirect.take   = 1'b0;
      redirect.target = br_target;
      case (dec.ctrl.pc_sel)
         PC_BRANCH: redirect.take = (dec.rs_data == dec.rt_data) ^ dec.ctrl.branch_ne;
         PC_JUMP: begin
            redirect.take   = 1'b1;
            redirect.target = j_target;
         end
         PC_JR: begin
            redirect.take   = 1'b1;
            redirect.target = dec.rs_data;
         end
         default: redirect.take = 1'b0;   // sequential
      endcase
   end

   // aligned word access only
   assign mem_addr     = alu_y[31:2];
   assign mem_data_in  = dec.rt_data;
   assign mem_write_en = {4{dec.ctrl.store & ~halted}};

   assign ex = '{result: alu_y, dst: dec.dst, load_kind: dec.ctrl.load_kind,
                 reg_we: dec.ctrl.reg_we, link: dec.ctrl.link};

endmodule

`default_nettype wire

//--- src/mips_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module mips_fetch #(
   parameter mips_isa_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic                      clk,
   input  logic                      rst_b,
   input  mips_core_pkg::redirect_t  redirect,
   input  logic                      halt_req,
   output mips_isa_pkg::word_t       pc,
   output mips_isa_pkg::word_addr_t  inst_addr,
   output logic                      halted
);
   import mips_isa_pkg::*;

   word_t pc_next;

   // no delay slot, a taken transfer goes straight into pc
   assign pc_next = redirect.take ? redirect.target : pc + 32'd4;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= text_start;
         halted <= 1'b0;
      end else if (!halted) begin
         halted <= halt_req;      // sticky until reset
         if (!halt_req) begin
            pc <= pc_next;
         end
      end
   end

   assign inst_addr = pc[31:2];   // word address

endmodule

`default_nettype wire

//--- src/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [29:0] word_addr_t;   // byte address >> 2
   typedef logic [4:0]  reg_idx_t;

   // primary opcodes kept in this core
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SW      = 6'h2b
   } opcode_e;

   // funct field of SPECIAL
   typedef enum logic [5:0] {
      F_SLL     = 6'h00,
      F_SRL     = 6'h02,
      F_SRA     = 6'h03,
      F_SLLV    = 6'h04,
      F_SRLV    = 6'h06,
      F_SRAV    = 6'h07,
      F_JR      = 6'h08,
      F_SYSCALL = 6'h0c,
      F_ADDU    = 6'h21,
      F_SUBU    = 6'h23,
      F_AND     = 6'h24,
      F_OR      = 6'h25,
      F_XOR     = 6'h26,
      F_NOR     = 6'h27,
      F_SLT     = 6'h2a
   } funct_e;

   // R-format view; imm16 is [15:0], jump target [25:0]
   typedef struct packed {
      logic [5:0] op;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } instr_t;

   localparam reg_idx_t reg_v0 = 5'd2;     // syscall code
   localparam reg_idx_t reg_ra = 5'd31;    // JAL link
   localparam word_t syscall_exit = 32'd10;

endpackage

`default_nettype wire

//--- src/mips_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
   input  logic                    clk,
   input  logic                    rst_b,
   input  mips_isa_pkg::reg_idx_t  rs_idx,
   input  mips_isa_pkg::reg_idx_t  rt_idx,
   input  mips_isa_pkg::reg_idx_t  wr_idx,
   input  logic                    wr_en,
   input  mips_isa_pkg::word_t     wr_data,
   output mips_isa_pkg::word_t     rs_data,
   output mips_isa_pkg::word_t     rt_data
);
   import mips_isa_pkg::*;

   word_t regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_idx != 5'd0)) begin   // $zero never written
         regs[wr_idx] <= wr_data;
      end
   end

   // combinational read, old value seen in the writing cycle
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

`default_nettype wire

//--- src/mips_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module mips_writeback (
   input  mips_core_pkg::ex_t      ex,
   input  mips_isa_pkg::word_t     mem_data_out,
   input  mips_isa_pkg::word_t     pc,
   input  logic                    halted,
   output logic                    wr_en,
   output mips_isa_pkg::reg_idx_t  wr_idx,
   output mips_isa_pkg::word_t     wr_data
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   logic [7:0]  byte_v;
   logic [15:0] half_v;
   word_t       load_v;

   // little-endian lanes picked by the address low bits
   assign byte_v = mem_data_out[{ex.result[1:0], 3'b000} +: 8];
   assign half_v = mem_data_out[{ex.result[1], 4'b0000} +: 16];

   always_comb begin
      case (ex.load_kind)
         LD_LB:   load_v = {{24{byte_v[7]}}, byte_v};
         LD_LBU:  load_v = {24'd0, byte_v};
         LD_LH:   load_v = {{16{half_v[15]}}, half_v};
         LD_LHU:  load_v = {16'd0, half_v};
         LD_LW:   load_v = mem_data_out;
         default: load_v = ex.result;   // not a load
      endcase
   end

   assign wr_data = ex.link ? pc + 32'd4 : load_v;   // JAL links to next instr
   assign wr_idx  = ex.dst;
   assign wr_en   = ex.reg_we & ~halted;

endmodule

`default_nettype wire
